//--- verilog/lynx_video_pkg.sv
`default_nettype none

package lynx_video_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths

  typedef logic [11:0] pixel_t;        // rgb444 as stored
  typedef logic [7:0]  channel_t;      // one output colour
  typedef logic [13:0] px_addr_t;      // up to 160x102 pixels
  typedef logic [1:0]  buf_idx_t;      // buffer 0..2
  typedef logic [31:0] settings_t;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // flicker blend depth, 3 is decoded like BLEND_THREE
  typedef enum logic [1:0] {
    BLEND_OFF   = 2'd0,
    BLEND_TWO   = 2'd1,
    BLEND_THREE = 2'd2
  } blend_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // bridge register map

  localparam bridge_addr_t RESET_CMD_ADDR = 32'hF000_0000;
  localparam bridge_addr_t SETTINGS_ADDR  = 32'hF200_0000;

  // runtime settings bits
  localparam int SET_FF_EN    = 3;
  localparam int SET_BUFF_VID = 4;
  localparam int SET_BLEND_LO = 7;   // two bits, 8:7

endpackage

`default_nettype wire

//--- verilog/host_regs.sv
`timescale 1ns/10ps
`default_nettype none

module host_regs
  import lynx_video_pkg::*;
#(
  parameter int RESET_HOLD = 8000
) (
  input  logic         clk_sys,
  input  logic         rst_n,
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  input  logic         bridge_rd,
  output bridge_data_t bridge_rd_data,
  output settings_t    settings,
  output logic         core_reset
);

  localparam int CW = $clog2(RESET_HOLD + 1);

  logic          reset_req;   // one cycle after a reset command
  logic [CW-1:0] hold_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // bridge write and read decode

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      settings       <= '0;
      reset_req      <= 1'b0;
      bridge_rd_data <= '0;
    end else begin
      reset_req <= bridge_wr && (bridge_addr == RESET_CMD_ADDR);

      if (bridge_wr && bridge_addr == SETTINGS_ADDR) begin
        settings <= bridge_wr_data;
      end

      // unmapped addresses read back as zero
      if (bridge_rd) begin
        bridge_rd_data <= (bridge_addr == SETTINGS_ADDR) ? settings : '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reset hold, counts down while core_reset is up

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt   <= '0;
      core_reset <= 1'b0;
    end else if (reset_req) begin
      hold_cnt   <= CW'(RESET_HOLD);   // reload, high from next cycle
      core_reset <= 1'b0;
    end else if (hold_cnt == '0) begin
      core_reset <= 1'b0;
    end else begin
      hold_cnt   <= hold_cnt - 1'b1;
      core_reset <= 1'b1;
    end
  end

  // core reset pulse is bounded by the hold count
  a_reset_len : assert property (@(posedge clk_sys) disable iff (!rst_n)
    $rose(core_reset) |-> ##[1:RESET_HOLD] !core_reset);

endmodule

`default_nettype wire

//--- verilog/frame_store.sv
`timescale 1ns/10ps
`default_nettype none

module frame_store
  import lynx_video_pkg::*;
#(
  parameter int FRAME_W = 160,
  parameter int FRAME_H = 102
) (
  input  logic     clk_sys,
  input  logic     rst_n,
  input  logic     buffer_en,
  input  logic     pix_we,
  input  px_addr_t pix_addr,
  input  pixel_t   pix_data,
  input  px_addr_t rd_addr,
  input  logic     frame_end,
  output pixel_t   cur_pix,
  output pixel_t   prev_pix,
  output pixel_t   pix0,
  output pixel_t   pix1,
  output pixel_t   pix2
);

  localparam int       FRAME_SIZE = FRAME_W * FRAME_H;
  localparam int       AW         = $clog2(FRAME_SIZE);
  localparam px_addr_t LAST_ADDR  = px_addr_t'(FRAME_SIZE - 1);

  buf_idx_t wr_idx;      // buffer taking emulator writes
  buf_idx_t ready_idx;   // last completed frame
  buf_idx_t rd_idx;      // buffer on screen
  buf_idx_t prev_idx;    // buffer shown one frame ago

  ////////////////////////////////////////////////////////////////////////////
  // three frame memories, all read every cycle

  for (genvar i = 0; i < 3; i++) begin : g_buf
    pixel_t mem [FRAME_SIZE];
    pixel_t rd_q;

    always_ff @(posedge clk_sys) begin
      if (pix_we && wr_idx == buf_idx_t'(i)) begin
        mem[pix_addr[AW-1:0]] <= pix_data;
      end
      rd_q <= mem[rd_addr[AW-1:0]];
    end
  end

  assign pix0 = g_buf[0].rd_q;
  assign pix1 = g_buf[1].rd_q;
  assign pix2 = g_buf[2].rd_q;

  function automatic pixel_t pick(input buf_idx_t idx, input pixel_t p0, input pixel_t p1,
                                  input pixel_t p2);
    case (idx)
      2'd0:    return p0;
      2'd1:    return p1;
      default: return p2;
    endcase
  endfunction

  assign cur_pix  = pick(rd_idx, pix0, pix1, pix2);
  assign prev_pix = pick(prev_idx, pix0, pix1, pix2);

  ////////////////////////////////////////////////////////////////////////////
  // buffer rotation

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx    <= '0;
      ready_idx <= '0;
      rd_idx    <= '0;
      prev_idx  <= '0;
    end else begin
      if (!buffer_en) begin
        wr_idx    <= '0;   // single buffer mode
        ready_idx <= '0;
      end else if (pix_we && pix_addr == LAST_ADDR) begin
        ready_idx <= wr_idx;
        wr_idx    <= (wr_idx == 2'd2) ? 2'd0 : wr_idx + 1'b1;
      end

      if (frame_end) begin
        rd_idx   <= ready_idx;
        prev_idx <= rd_idx;
      end
    end
  end

  a_idx_range : assert property (@(posedge clk_sys) disable iff (!rst_n)
    wr_idx <= 2'd2 && ready_idx <= 2'd2 && rd_idx <= 2'd2 && prev_idx <= 2'd2);

  a_wr_addr : assert property (@(posedge clk_sys) disable iff (!rst_n)
    pix_we |-> pix_addr <= LAST_ADDR);

endmodule

`default_nettype wire

//--- verilog/frame_blend.sv
`timescale 1ns/10ps
`default_nettype none

module frame_blend
  import lynx_video_pkg::*;
(
  input  blend_mode_t blend_mode,
  input  pixel_t      cur_pix,
  input  pixel_t      prev_pix,
  input  pixel_t      pix0,
  input  pixel_t      pix1,
  input  pixel_t      pix2,
  output channel_t    blend_r,
  output channel_t    blend_g,
  output channel_t    blend_b
);

  // one 4-bit colour component through the blend
  function automatic channel_t blend_ch(
    input blend_mode_t mode,
    input logic [3:0]  now,
    input logic [3:0]  last,
    input logic [3:0]  c0,
    input logic [3:0]  c1,
    input logic [3:0]  c2
  );
    logic [4:0]  sum2;
    logic [5:0]  sum3;
    logic [7:0]  sum3_8;
    logic [23:0] scaled;

    sum2   = 5'(now) + 5'(last);
    sum3   = 6'(c0) + 6'(c1) + 6'(c2);
    sum3_8 = {sum3, sum3[5:4]};
    // x 21845 / 16384, roughly 4/3
    scaled = (24'(sum3_8) * 24'd21845) >> 14;

    case (mode)
      BLEND_OFF: return {now, now};
      BLEND_TWO: return {sum2, sum2[4:2]};
      default:   return scaled[7:0];   // three frames, also code 3
    endcase
  endfunction

  assign blend_r = blend_ch(blend_mode, cur_pix[11:8], prev_pix[11:8],
                            pix0[11:8], pix1[11:8], pix2[11:8]);
  assign blend_g = blend_ch(blend_mode, cur_pix[7:4], prev_pix[7:4],
                            pix0[7:4], pix1[7:4], pix2[7:4]);
  assign blend_b = blend_ch(blend_mode, cur_pix[3:0], prev_pix[3:0],
                            pix0[3:0], pix1[3:0], pix2[3:0]);

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing
  import lynx_video_pkg::*;
#(
  parameter int FRAME_W     = 160,
  parameter int FRAME_H     = 102,
  parameter int LINE_LEN    = 445,
  parameter int FRAME_LINES = 270,
  parameter int V_START     = 120,
  parameter int HS_START    = 350,
  parameter int HS_LEN      = 32,
  parameter int PIX_DIV     = 9
) (
  input  logic     clk_sys,
  input  logic     rst_n,
  input  channel_t blend_r,
  input  channel_t blend_g,
  input  channel_t blend_b,
  output px_addr_t rd_addr,
  output logic     frame_end,
  output channel_t video_r,
  output channel_t video_g,
  output channel_t video_b,
  output logic     video_hs,
  output logic     video_vs,
  output logic     video_hblank,
  output logic     video_vblank,
  output logic     pix_valid
);

  localparam int XW = $clog2(LINE_LEN);
  localparam int YW = $clog2(FRAME_LINES);
  localparam int DW = $clog2(PIX_DIV + 1);

  localparam logic [DW-1:0] D_LAST    = DW'(PIX_DIV - 1);
  localparam logic [XW-1:0] X_LAST    = XW'(LINE_LEN - 1);
  localparam logic [XW-1:0] X_ACT_END = XW'(FRAME_W);
  localparam logic [XW-1:0] HS_BEG    = XW'(HS_START);
  localparam logic [XW-1:0] HS_END    = XW'(HS_START + HS_LEN);
  localparam logic [YW-1:0] Y_LAST    = YW'(FRAME_LINES - 1);
  localparam logic [YW-1:0] Y_ACT_BEG = YW'(V_START);
  localparam logic [YW-1:0] Y_ACT_END = YW'(V_START + FRAME_H);
  localparam logic [YW-1:0] Y_VS_BEG  = YW'(1);
  localparam logic [YW-1:0] Y_VS_END  = YW'(4);
  localparam px_addr_t      ADDR_LAST = px_addr_t'(FRAME_W * FRAME_H - 1);

  logic [DW-1:0] div;
  logic          pix_en;
  logic [XW-1:0] x;
  logic [YW-1:0] y;
  logic          x_act;
  logic          y_act;

  assign pix_en = (div == '0);
  assign x_act  = (x < X_ACT_END);
  assign y_act  = (y >= Y_ACT_BEG) && (y < Y_ACT_END);

  ////////////////////////////////////////////////////////////////////////////
  // pixel clock divider and raster counters

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      div       <= '0;
      x         <= '0;
      y         <= '0;
      frame_end <= 1'b0;
    end else begin
      div       <= (div == D_LAST) ? '0 : div + 1'b1;
      frame_end <= 1'b0;

      if (pix_en) begin
        if (x == X_LAST) begin
          x <= '0;
          if (y == Y_LAST) begin
            y         <= '0;
            frame_end <= 1'b1;   // raster wrap
          end else begin
            y <= y + 1'b1;
          end
        end else begin
          x <= x + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // syncs, blanks and framebuffer read address

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      video_hs     <= 1'b0;
      video_vs     <= 1'b0;
      video_hblank <= 1'b1;
      video_vblank <= 1'b1;
      pix_valid    <= 1'b0;
      rd_addr      <= '0;
    end else begin
      pix_valid <= pix_en;
      if (pix_en) begin
        video_hblank <= !x_act;
        video_vblank <= !y_act;
        video_hs     <= (x >= HS_BEG) && (x < HS_END);
        video_vs     <= (y >= Y_VS_BEG) && (y < Y_VS_END);   // lines 1..3

        // address of the next active pixel
        if (!y_act) begin
          rd_addr <= '0;
        end else if (x_act) begin
          rd_addr <= (rd_addr == ADDR_LAST) ? '0 : rd_addr + 1'b1;
        end
      end
    end
  end

  // blend output settles between enables
  always_ff @(posedge clk_sys) begin
    if (pix_en) begin
      video_r <= blend_r;
      video_g <= blend_g;
      video_b <= blend_b;
    end
  end

  a_rd_addr : assert property (@(posedge clk_sys) disable iff (!rst_n)
    rd_addr <= ADDR_LAST);

endmodule

`default_nettype wire

//--- verilog/ff_latch.sv
`timescale 1ns/10ps
`default_nettype none

module ff_latch #(
  parameter int FF_TAP_CYCLES = 6400000
) (
  input  logic clk_sys,
  input  logic rst_n,
  input  logic ff_button,
  input  logic ff_en,
  output logic fast_forward
);

  localparam int CW = $clog2(FF_TAP_CYCLES + 1);
  localparam logic [CW-1:0] TAP_MAX = CW'(FF_TAP_CYCLES);

  logic          ff_act;
  logic          ff_last;
  logic          tap_set;    // last release set the latch
  logic          latch_on;
  logic [CW-1:0] press_cnt;

  assign ff_act = ff_button & ff_en;

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      ff_last      <= 1'b0;
      tap_set      <= 1'b0;
      latch_on     <= 1'b0;
      press_cnt    <= '0;
      fast_forward <= 1'b0;
    end else begin
      ff_last <= ff_act;

      if (ff_act && !ff_last) begin
        latch_on  <= 1'b0;   // new press clears
        press_cnt <= '0;
      end else if (ff_act && press_cnt != TAP_MAX) begin
        press_cnt <= press_cnt + 1'b1;
      end

      // release, short press toggles into the latch
      if (!ff_act && ff_last) begin
        tap_set <= 1'b0;
        if (press_cnt < TAP_MAX && !tap_set) begin
          tap_set  <= 1'b1;
          latch_on <= 1'b1;
        end
      end

      fast_forward <= ff_act | latch_on;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lynx_video_top.sv
`timescale 1ns/10ps
`default_nettype none

module lynx_video_top
  import lynx_video_pkg::*;
#(
  parameter int FRAME_W       = 160,
  parameter int FRAME_H       = 102,
  parameter int LINE_LEN      = 445,
  parameter int FRAME_LINES   = 270,
  parameter int V_START       = 120,
  parameter int HS_START      = 350,
  parameter int HS_LEN        = 32,
  parameter int PIX_DIV       = 9,
  parameter int RESET_HOLD    = 8000,
  parameter int FF_TAP_CYCLES = 6400000
) (
  input  logic         clk_sys,
  input  logic         rst_n,
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  input  logic         bridge_rd,
  input  logic         pix_we,
  input  px_addr_t     pix_addr,
  input  pixel_t       pix_data,
  input  logic         ff_button,
  output bridge_data_t bridge_rd_data,
  output logic         core_reset,
  output channel_t     video_r,
  output channel_t     video_g,
  output channel_t     video_b,
  output logic         video_hs,
  output logic         video_vs,
  output logic         video_hblank,
  output logic         video_vblank,
  output logic         pix_valid,
  output logic         fast_forward
);

  settings_t settings;
  px_addr_t  rd_addr;
  logic      frame_end;
  pixel_t    cur_pix, prev_pix;
  pixel_t    pix0, pix1, pix2;
  channel_t  blend_r, blend_g, blend_b;

  ////////////////////////////////////////////////////////////////////////////
  // host side

  host_regs #(
    .RESET_HOLD     ( RESET_HOLD     )
  ) host_regs_i (
    .clk_sys        ( clk_sys        ),
    .rst_n          ( rst_n          ),
    .bridge_addr    ( bridge_addr    ),
    .bridge_wr      ( bridge_wr      ),
    .bridge_wr_data ( bridge_wr_data ),
    .bridge_rd      ( bridge_rd      ),
    .bridge_rd_data ( bridge_rd_data ),
    .settings       ( settings       ),
    .core_reset     ( core_reset     )
  );

  ff_latch #(
    .FF_TAP_CYCLES ( FF_TAP_CYCLES       )
  ) ff_latch_i (
    .clk_sys       ( clk_sys             ),
    .rst_n         ( rst_n               ),
    .ff_button     ( ff_button           ),
    .ff_en         ( settings[SET_FF_EN] ),
    .fast_forward  ( fast_forward        )
  );

  ////////////////////////////////////////////////////////////////////////////
  // video path

  frame_store #(
    .FRAME_W   ( FRAME_W                ),
    .FRAME_H   ( FRAME_H                )
  ) frame_store_i (
    .clk_sys   ( clk_sys                ),
    .rst_n     ( rst_n                  ),
    .buffer_en ( settings[SET_BUFF_VID] ),
    .pix_we    ( pix_we                 ),
    .pix_addr  ( pix_addr               ),
    .pix_data  ( pix_data               ),
    .rd_addr   ( rd_addr                ),
    .frame_end ( frame_end              ),
    .cur_pix   ( cur_pix                ),
    .prev_pix  ( prev_pix               ),
    .pix0      ( pix0                   ),
    .pix1      ( pix1                   ),
    .pix2      ( pix2                   )
  );

  frame_blend frame_blend_i (
    .blend_mode ( blend_mode_t'(settings[SET_BLEND_LO +: 2]) ),
    .cur_pix    ( cur_pix                                    ),
    .prev_pix   ( prev_pix                                   ),
    .pix0       ( pix0                                       ),
    .pix1       ( pix1                                       ),
    .pix2       ( pix2                                       ),
    .blend_r    ( blend_r                                    ),
    .blend_g    ( blend_g                                    ),
    .blend_b    ( blend_b                                    )
  );

  video_timing #(
    .FRAME_W      ( FRAME_W      ),
    .FRAME_H      ( FRAME_H      ),
    .LINE_LEN     ( LINE_LEN     ),
    .FRAME_LINES  ( FRAME_LINES  ),
    .V_START      ( V_START      ),
    .HS_START     ( HS_START     ),
    .HS_LEN       ( HS_LEN       ),
    .PIX_DIV      ( PIX_DIV      )
  ) video_timing_i (
    .clk_sys      ( clk_sys      ),
    .rst_n        ( rst_n        ),
    .blend_r      ( blend_r      ),
    .blend_g      ( blend_g      ),
    .blend_b      ( blend_b      ),
    .rd_addr      ( rd_addr      ),
    .frame_end    ( frame_end    ),
    .video_r      ( video_r      ),
    .video_g      ( video_g      ),
    .video_b      ( video_b      ),
    .video_hs     ( video_hs     ),
    .video_vs     ( video_vs     ),
    .video_hblank ( video_hblank ),
    .video_vblank ( video_vblank ),
    .pix_valid    ( pix_valid    )
  );

endmodule

`default_nettype wire

//--- verif/tb_lynx_video.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lynx_video
  import lynx_video_pkg::*;
();

  localparam int FRAME_W       = 8;
  localparam int FRAME_H       = 4;
  localparam int LINE_LEN      = 14;
  localparam int FRAME_LINES   = 8;
  localparam int V_START       = 2;
  localparam int HS_START      = 10;
  localparam int HS_LEN        = 2;
  localparam int PIX_DIV       = 3;
  localparam int RESET_HOLD    = 10;
  localparam int FF_TAP_CYCLES = 20;
  localparam int FRAME_SIZE    = FRAME_W * FRAME_H;
  localparam int FRAME_CYC     = LINE_LEN * FRAME_LINES * PIX_DIV;

  logic         clk_sys;
  logic         rst_n;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  logic         bridge_rd;
  logic         pix_we;
  px_addr_t     pix_addr;
  pixel_t       pix_data;
  logic         ff_button;
  bridge_data_t bridge_rd_data;
  logic         core_reset;
  channel_t     video_r;
  channel_t     video_g;
  channel_t     video_b;
  logic         video_hs;
  logic         video_vs;
  logic         video_hblank;
  logic         video_vblank;
  logic         pix_valid;
  logic         fast_forward;

  // reference model of the three buffers and their indices
  pixel_t    mem_m [3][FRAME_SIZE];
  int        wr_m;
  int        ready_m;
  int        rd_m;
  int        prev_m;
  settings_t settings_m;

  int rx;          // raster position of the next pix_valid sample
  int ry;
  int frame_cnt;
  int act_cnt;
  int hs_cnt;
  bit chk_req;
  bit chk_act;
  bit chk_done;

  int err_val;
  int err_other;
  int cycles;
  int cycle_limit;

  logic [7:0]  op_q [$];
  logic [31:0] a1_q [$];
  logic [31:0] a2_q [$];
  logic [31:0] a3_q [$];

  lynx_video_top #(
    .FRAME_W (FRAME_W), .FRAME_H (FRAME_H), .LINE_LEN (LINE_LEN),
    .FRAME_LINES (FRAME_LINES), .V_START (V_START), .HS_START (HS_START),
    .HS_LEN (HS_LEN), .PIX_DIV (PIX_DIV), .RESET_HOLD (RESET_HOLD),
    .FF_TAP_CYCLES (FF_TAP_CYCLES)
  ) lynx_video_top_i (
    .clk_sys (clk_sys), .rst_n (rst_n), .bridge_addr (bridge_addr),
    .bridge_wr (bridge_wr), .bridge_wr_data (bridge_wr_data), .bridge_rd (bridge_rd),
    .pix_we (pix_we), .pix_addr (pix_addr), .pix_data (pix_data),
    .ff_button (ff_button), .bridge_rd_data (bridge_rd_data), .core_reset (core_reset),
    .video_r (video_r), .video_g (video_g), .video_b (video_b),
    .video_hs (video_hs), .video_vs (video_vs), .video_hblank (video_hblank),
    .video_vblank (video_vblank), .pix_valid (pix_valid), .fast_forward (fast_forward)
  );

  initial clk_sys = 1'b0;
  always #4 clk_sys = ~clk_sys;   // 8 ns period

  always @(posedge clk_sys) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run stopped: the DUT made no progress within %0d cycles", cycle_limit);
      $display("errors: value %0d, other %0d", err_val, err_other);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected pixel values

  function automatic int nib(input pixel_t px, input int k);
    return int'(px[k*4 +: 4]);
  endfunction

  function automatic channel_t expect_ch(input logic [1:0] mode, input int c, input int p,
                                         input int n0, input int n1, input int n2);
    int s;
    int v;
    case (mode)
      2'd0: s = c * 17;   // nibble repeated
      2'd1: begin
        s = c + p;
        s = s * 8 + s / 4;
      end
      default: begin
        v = n0 + n1 + n2;
        v = v * 4 + v / 16;
        s = (v * 21845) / 16384;
      end
    endcase
    return channel_t'(s);
  endfunction

  function automatic channel_t model_ch(input int n, input int k);
    return expect_ch(settings_m[SET_BLEND_LO +: 2], nib(mem_m[rd_m][n], k),
                     nib(mem_m[prev_m][n], k), nib(mem_m[0][n], k),
                     nib(mem_m[1][n], k), nib(mem_m[2][n], k));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // raster monitor on the falling edge

  task automatic check_sample();
    logic exp_hb;
    logic exp_vb;
    logic exp_vs;
    int   n;
    exp_hb = (rx >= FRAME_W);
    exp_vb = !(ry >= V_START && ry < V_START + FRAME_H);
    exp_vs = (ry >= 1 && ry < 4);
    if (video_hblank !== exp_hb || video_vblank !== exp_vb || video_vs !== exp_vs) begin
      $display("** Error %0t: blank/vs %b%b%b at x %0d y %0d, expected %b%b%b", $time,
               video_hblank, video_vblank, video_vs, rx, ry, exp_hb, exp_vb, exp_vs);
      err_val++;
    end
    if (video_hs) hs_cnt++;
    if (video_hblank === 1'b0 && video_vblank === 1'b0) act_cnt++;
    if (!exp_hb && !exp_vb) begin
      n = (ry - V_START) * FRAME_W + rx;
      if (video_r !== model_ch(n, 2) || video_g !== model_ch(n, 1) ||
          video_b !== model_ch(n, 0)) begin
        $display("** Error %0t: pixel %0d is %h %h %h, expected %h %h %h", $time, n,
                 video_r, video_g, video_b, model_ch(n, 2), model_ch(n, 1), model_ch(n, 0));
        err_val++;
      end
    end
  endtask

  always @(negedge clk_sys) begin
    if (rst_n && pix_valid) begin
      if (rx == 0 && ry == 0) begin
        frame_cnt++;
        if (chk_req) begin
          chk_act = 1'b1;
          chk_req = 1'b0;
          act_cnt = 0;
        end
      end
      if (chk_act) check_sample();
      if (rx == LINE_LEN - 1) begin
        if (chk_act && hs_cnt != HS_LEN) begin
          $display("** Error %0t: %0d hs enables on line %0d, expected %0d", $time,
                   hs_cnt, ry, HS_LEN);
          err_val++;
        end
        hs_cnt = 0;
        if (ry == FRAME_LINES - 1) begin
          if (chk_act) begin
            if (act_cnt != FRAME_SIZE) begin
              $display("** Error %0t: %0d active pixels, expected %0d", $time,
                       act_cnt, FRAME_SIZE);
              err_val++;
            end
            chk_act  = 1'b0;
            chk_done = 1'b1;
          end
          prev_m = rd_m;   // buffer swap at raster wrap
          rd_m   = ready_m;
        end
      end
      rx = (rx == LINE_LEN - 1) ? 0 : rx + 1;
      if (rx == 0) ry = (ry == FRAME_LINES - 1) ? 0 : ry + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_sys);
    #1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    if (addr == SETTINGS_ADDR) begin
      settings_m = data;
      if (!data[SET_BUFF_VID]) begin
        wr_m    = 0;
        ready_m = 0;
      end
    end
    @(posedge clk_sys);
    #1;
    bridge_wr = 1'b0;
  endtask

  task automatic bridge_read(input logic [31:0] addr, input logic [31:0] exp_data);
    @(posedge clk_sys);
    #1;
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(posedge clk_sys);
    #1;
    bridge_rd = 1'b0;
    if (bridge_rd_data !== exp_data) begin
      $display("** Error %0t: read of %h gave %h, expected %h", $time, addr,
               bridge_rd_data, exp_data);
      err_val++;
    end
  endtask

  task automatic reset_command(input int hold);
    int cnt;
    @(posedge clk_sys);
    #1;
    bridge_addr = RESET_CMD_ADDR;
    bridge_wr   = 1'b1;
    @(posedge clk_sys);
    #1;
    bridge_wr = 1'b0;
    @(negedge clk_sys);
    @(negedge clk_sys);
    if (core_reset !== 1'b0) begin
      $display("** Error %0t: core_reset rose too early", $time);
      err_val++;
    end
    cnt = 0;
    @(negedge clk_sys);
    while (core_reset === 1'b1 && cnt < 4 * hold + 8) begin
      cnt++;
      @(negedge clk_sys);
    end
    if (cnt != hold) begin
      $display("** Error %0t: core_reset high %0d cycles, expected %0d", $time, cnt, hold);
      err_val++;
    end
  endtask

  task automatic fill_frame();
    int start;
    pixel_t px;
    start = frame_cnt;
    wait (frame_cnt != start);   // write early in a frame
    for (int a = 0; a < FRAME_SIZE; a++) begin
      @(posedge clk_sys);
      #1;
      px       = pixel_t'($urandom);
      pix_we   = 1'b1;
      pix_addr = px_addr_t'(a);
      pix_data = px;
      mem_m[wr_m][a] = px;
      if (a == FRAME_SIZE - 1 && settings_m[SET_BUFF_VID]) begin
        ready_m = wr_m;
        wr_m    = (wr_m + 1) % 3;
      end
    end
    @(posedge clk_sys);
    #1;
    pix_we = 1'b0;
  endtask

  task automatic check_frame();
    chk_done = 1'b0;
    chk_req  = 1'b1;
    wait (chk_done);
  endtask

  task automatic press_button(input int len, input logic during, input logic after);
    @(posedge clk_sys);
    #1;
    ff_button = 1'b1;
    repeat (len) begin
      @(posedge clk_sys);
      @(negedge clk_sys);
      if (fast_forward !== during) begin
        $display("** Error %0t: fast_forward %b while held, expected %b", $time,
                 fast_forward, during);
        err_val++;
      end
    end
    @(posedge clk_sys);
    #1;
    ff_button = 1'b0;
    repeat (4) @(negedge clk_sys);
    if (fast_forward !== after) begin
      $display("** Error %0t: fast_forward %b after release, expected %b", $time,
               fast_forward, after);
      err_val++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // vector file

  task automatic load_vectors(output bit ok);
    int              fd;
    int              rc;
    logic [63:0]     op;
    logic [31:0]     a1;
    logic [31:0]     a2;
    logic [31:0]     a3;
    logic [8*128-1:0] line;
    ok = 1'b0;
    fd = $fopen("verif/lynx_video_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      cycle_limit = 8 * PIX_DIV + 8 * FRAME_CYC;   // reset plus margin
      while ($fscanf(fd, "%s", op) == 1) begin
        a1 = '0;
        a2 = '0;
        a3 = '0;
        if (op[7:0] == "#") begin
          rc = $fgets(line, fd);
        end else begin
          // rc ends up zero when all arguments were read
          case (op[7:0])
            "W", "R": rc = $fscanf(fd, "%h %h", a1, a2) - 2;
            "C":      rc = $fscanf(fd, "%h", a1) - 1;
            "B":      rc = $fscanf(fd, "%h %h %h", a1, a2, a3) - 3;
            default:  rc = 0;
          endcase
          if (rc != 0) begin
            $display("vector file entry %0d has missing arguments", op_q.size());
            err_other++;
          end
          op_q.push_back(op[7:0]);
          a1_q.push_back(a1);
          a2_q.push_back(a2);
          a3_q.push_back(a3);
          case (op[7:0])
            "F", "D": cycle_limit += 2 * FRAME_CYC;
            "C", "B": cycle_limit += 4 * int'(a1) + 16;
            default:  cycle_limit += 4;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vectors();
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": bridge_write(a1_q[i], a2_q[i]);
        "R": bridge_read(a1_q[i], a2_q[i]);
        "C": reset_command(int'(a1_q[i]));
        "F": fill_frame();
        "D": check_frame();
        "B": press_button(int'(a1_q[i]), a2_q[i][0], a3_q[i][0]);
        default: begin
          $display("unknown command in vector file at entry %0d", i);
          err_other++;
        end
      endcase
    end
  endtask

  initial begin
    bit ok;
    rst_n          = 1'b0;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    bridge_rd      = 1'b0;
    pix_we         = 1'b0;
    pix_addr       = '0;
    pix_data       = '0;
    ff_button      = 1'b0;
    settings_m     = '0;
    wr_m = 0;
    ready_m = 0;
    rd_m = 0;
    prev_m = 0;
    rx = 0;
    ry = 0;
    frame_cnt = 0;
    act_cnt = 0;
    hs_cnt = 0;
    chk_req = 1'b0;
    chk_act = 1'b0;
    chk_done = 1'b0;
    err_val = 0;
    err_other = 0;
    cycles = 0;
    cycle_limit = 0;
    void'($urandom(32'h02c4_d4cc));
    load_vectors(ok);
    if (!ok) begin
      $display("could not open verif/lynx_video_vectors.txt");
      $display("TB FAILED");
      $finish;
    end else begin
      repeat (8) @(posedge clk_sys);
      #1;
      rst_n = 1'b1;
      run_vectors();
      $display("errors: value %0d, other %0d", err_val, err_other);
      if (err_val + err_other == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/lynx_video_vectors.txt
# columns: op arg1 arg2 arg3, all hex; W addr data, R addr expect, C hold
# F fill frame, D check next frame, B press_len expect_held expect_released
W f2000000 a5a55a5a
R f2000000 a5a55a5a
R f1000000 00000000
W f2000000 0000c3f0
R f2000000 0000c3f0
C 0a
W f2000000 00000000
F
D
F
D
W f2000000 00000090
F
D
F
D
F
D
W f2000000 00000110
D
W f2000000 00000190
D
W f2000000 00000008
B 1e 1 0
B 05 1 1
B 05 1 0
B 05 1 1
B 1e 1 0
W f2000000 00000000
B 05 0 0
B 1e 0 0

//--- tb.f
verilog/lynx_video_pkg.sv
verilog/host_regs.sv
verilog/frame_store.sv
verilog/frame_blend.sv
verilog/video_timing.sv
verilog/ff_latch.sv
verilog/lynx_video_top.sv
verif/tb_lynx_video.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, run from the project root
verilator --binary --timing --assert -f tb.f --top-module tb_lynx_video -o tb_lynx_video \
  && ./obj_dir/tb_lynx_video | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }
